// ==== sources.f ====
verilog/clock_pkg.sv
verilog/time_if.sv
verilog/tick_gen.sv
verilog/button_ctrl.sv
verilog/time_counter.sv
verilog/digit_frame.sv
verilog/display_scan.sv
verilog/digital_clock_top.sv
testbench/tb_digital_clock.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_digital_clock
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	@if grep -q "RESULT: FAIL" $(SIM_LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(SIM_LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== testbench/tb_digital_clock.sv ====
module tb_digital_clock;
	import clock_pkg::*;

	localparam int SEC_DIV   = 200;
	localparam int SCAN_DIV  = 4;
	localparam int DEB_DIV   = 3;
	localparam int PRESS_CYC = 8 * DEB_DIV;	// 4 periods high, 4 low

	typedef seg_t [NUM_DIGITS-1:0] frame_t;

	typedef enum int {
		ACT_MODE,
		ACT_POS,
		ACT_INC,
		ACT_RUN,
		ACT_HOLD,
		ACT_CHECK
	} act_e;

	typedef struct {
		act_e act;
		int   n;	// presses or seconds
		int   hr;
		int   min;
		int   sec;
	} step_t;

	logic                  clk;
	logic                  rst_n;
	logic                  btn_mode;
	logic                  btn_pos;
	logic                  btn_inc;
	seg_t                  o_seg;
	logic [NUM_DIGITS-1:0] o_seg_en;

	step_t steps[$];
	int    errors;
	int    failed;
	int    cycles = 0;
	int    limit = 0;
	int    last_chg = -1;	// cycle of the last seen time step
	int    cur_h;
	int    cur_m;
	int    cur_s;

	digital_clock_top #(
		.SEC_DIV  (SEC_DIV),
		.SCAN_DIV (SCAN_DIV),
		.DEB_DIV  (DEB_DIV)
	) u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_btn_mode (btn_mode),
		.i_btn_pos  (btn_pos),
		.i_btn_inc  (btn_inc),
		.o_seg      (o_seg),
		.o_seg_en   (o_seg_en)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("timeout after %0d cycles, the display sequence did not complete", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// --------------------
	// helpers
	// --------------------
	task automatic add_step(input act_e act, input int n, input int hr, input int min,
			input int sec);
		step_t s;
		s.act = act;
		s.n   = n;
		s.hr  = hr;
		s.min = min;
		s.sec = sec;
		steps.push_back(s);
	endtask

	// expected frame, hour tens first
	function automatic frame_t to_frame(input int hr, input int min, input int sec);
		frame_t f;
		f[0] = SEG_TABLE[4'(hr / 10)];
		f[1] = SEG_TABLE[4'(hr % 10)];
		f[2] = SEG_TABLE[4'(min / 10)];
		f[3] = SEG_TABLE[4'(min % 10)];
		f[4] = SEG_TABLE[4'(sec / 10)];
		f[5] = SEG_TABLE[4'(sec % 10)];
		return f;
	endfunction

	task automatic check_seg(input int digit, input seg_t got, input seg_t exp);
		if (got !== exp) begin
			errors++;
			$display("** Error: o_seg digit %0d = 0x%h, expected 0x%h", digit, got, exp);
		end
	endtask

	task automatic check_en(input logic [NUM_DIGITS-1:0] en);
		if (!$onehot(~en)) begin
			errors++;
			$display("** Error: o_seg_en = 0x%h, expected exactly one bit low", en);
		end
	endtask

	task automatic compare_frame(input frame_t got, input int hr, input int min, input int sec);
		frame_t exp;
		exp = to_frame(hr, min, sec);
		for (int i = 0; i < NUM_DIGITS; i++) begin
			check_seg(i, got[i], exp[i]);
		end
	endtask

	// reader latency varies by well under half a second period
	task automatic expect_one_second();
		int secs;
		if (last_chg >= 0) begin
			secs = (cycles - last_chg + SEC_DIV / 2) / SEC_DIV;
			if (secs != 1) begin
				errors++;
				$display("time advanced one second %0d cycles after the previous step, expected %0d",
					cycles - last_chg, SEC_DIV);
			end
		end
		last_chg = cycles;
	endtask

	task automatic press_button(input act_e act);
		@(negedge clk);
		case (act)
			ACT_MODE: btn_mode = 1'b1;
			ACT_POS:  btn_pos = 1'b1;
			default:  btn_inc = 1'b1;
		endcase
		repeat (4 * DEB_DIV) @(negedge clk);
		btn_mode = 1'b0;
		btn_pos  = 1'b0;
		btn_inc  = 1'b0;
		repeat (4 * DEB_DIV - 1) @(negedge clk);
	endtask

	// --------------------
	// display reader
	// --------------------
	task automatic read_round(output frame_t f);
		logic [NUM_DIGITS-1:0] last_en;
		logic [NUM_DIGITS-1:0] seen;
		f    = '0;
		seen = '0;
		@(negedge clk);
		last_en = o_seg_en;
		while (seen != '1) begin
			@(negedge clk);
			check_en(o_seg_en);
			if (o_seg_en != last_en) begin
				last_en = o_seg_en;
				for (int i = 0; i < NUM_DIGITS; i++) begin
					if (!o_seg_en[i]) begin
						f[i]    = o_seg;
						seen[i] = 1'b1;
					end
				end
			end
		end
	endtask

	// two equal rounds in a row, so a frame torn by an update is skipped
	task automatic read_stable(output frame_t f);
		frame_t prev;
		read_round(prev);
		read_round(f);
		while (f != prev) begin
			prev = f;
			read_round(f);
		end
	endtask

	task automatic step_time();
		cur_s = (cur_s + 1) % 60;
		if (cur_s == 0) begin
			cur_m = (cur_m + 1) % 60;
			if (cur_m == 0) begin
				cur_h = (cur_h + 1) % 24;
			end
		end
	endtask

	task automatic run_seconds(input int n);
		frame_t prev;
		frame_t f;
		int     done;
		done = 0;
		read_stable(prev);
		if (prev != to_frame(cur_h, cur_m, cur_s)) begin
			step_time();	// a tick came before the first read
			compare_frame(prev, cur_h, cur_m, cur_s);
			expect_one_second();
			done = 1;
		end
		while (done < n) begin
			read_stable(f);
			if (f != prev) begin
				step_time();
				compare_frame(f, cur_h, cur_m, cur_s);
				expect_one_second();
				prev = f;
				done++;
			end
		end
	endtask

	// --------------------
	// stimulus table and main loop
	// --------------------
	initial begin
		frame_t f;
		int     cs;
		int     cm;
		int     ch;
		int     first_err;
		void'($urandom(3636));
		rst_n    = 1'b0;
		btn_mode = 1'b0;
		btn_pos  = 1'b0;
		btn_inc  = 1'b0;
		errors   = 0;
		failed   = 0;
		cur_h    = 0;
		cur_m    = 0;
		cur_s    = 0;
		cs = $urandom_range(70, 1);
		cm = $urandom_range(70, 1);
		ch = $urandom_range(30, 1);

		add_step(ACT_CHECK, 0, 0, 0, 0);	// reset value
		add_step(ACT_MODE, 1, 0, 0, 0);
		add_step(ACT_INC, cs, 0, 0, 0);
		add_step(ACT_CHECK, 0, 0, 0, cs % 60);
		add_step(ACT_POS, 1, 0, 0, 0);
		add_step(ACT_INC, cm, 0, 0, 0);
		add_step(ACT_CHECK, 0, 0, cm % 60, cs % 60);
		add_step(ACT_POS, 1, 0, 0, 0);
		add_step(ACT_INC, ch, 0, 0, 0);
		add_step(ACT_CHECK, 0, ch % 24, cm % 60, cs % 60);
		add_step(ACT_HOLD, 6, ch % 24, cm % 60, cs % 60);	// setup freezes time
		add_step(ACT_POS, 1, 0, 0, 0);
		add_step(ACT_INC, (57 - cs % 60 + 60) % 60, 0, 0, 0);
		add_step(ACT_POS, 1, 0, 0, 0);
		add_step(ACT_INC, (59 - cm % 60 + 60) % 60, 0, 0, 0);
		add_step(ACT_POS, 1, 0, 0, 0);
		add_step(ACT_INC, (23 - ch % 24 + 24) % 24, 0, 0, 0);
		add_step(ACT_CHECK, 0, 23, 59, 57);
		add_step(ACT_MODE, 1, 0, 0, 0);
		add_step(ACT_RUN, 3, 0, 0, 0);	// through midnight
		add_step(ACT_POS, 1, 0, 0, 0);	// ignored in clock mode
		add_step(ACT_INC, 1, 0, 0, 0);
		add_step(ACT_RUN, 3, 0, 0, 0);

		foreach (steps[i]) begin
			case (steps[i].act)
				ACT_RUN, ACT_HOLD: limit += (steps[i].n + 1) * (SEC_DIV + 100);
				ACT_CHECK:         limit += 100;
				default:           limit += steps[i].n * PRESS_CYC;
			endcase
		end
		limit = 2 * limit + 1000;

		repeat (4) @(negedge clk);
		rst_n = 1'b1;

		foreach (steps[i]) begin
			first_err = errors;
			case (steps[i].act)
				ACT_MODE, ACT_POS: press_button(steps[i].act);
				ACT_INC:           repeat (steps[i].n) press_button(ACT_INC);
				ACT_RUN:           run_seconds(steps[i].n);
				default: begin
					if (steps[i].act == ACT_HOLD) begin
						repeat (steps[i].n * SEC_DIV) @(negedge clk);
					end
					read_stable(f);
					compare_frame(f, steps[i].hr, steps[i].min, steps[i].sec);
					cur_h = steps[i].hr;
					cur_m = steps[i].min;
					cur_s = steps[i].sec;
				end
			endcase
			if (errors != first_err) begin
				failed++;
			end
			$display("test %0d %s n=%0d: %s", i, steps[i].act.name(), steps[i].n,
				(errors == first_err) ? "ok" : "FAILED");
		end

		$display("tests %0d, failed %0d, errors %0d", steps.size(), failed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== verilog/digital_clock_top.sv ====
module digital_clock_top #(
	parameter int SEC_DIV  = 50_000_000,
	parameter int SCAN_DIV = 5_000,
	parameter int DEB_DIV  = 500_000
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              i_btn_mode,
	input  logic                              i_btn_pos,
	input  logic                              i_btn_inc,
	output clock_pkg::seg_t                   o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0]  o_seg_en
);
	import clock_pkg::*;

	logic                   sec_tick;
	logic                   scan_tick;
	logic                   deb_tick;
	mode_e                  mode;
	pos_e                   pos;
	logic                   inc;
	seg_t [NUM_DIGITS-1:0]  frame;

	time_if u_time_if ();

	// --------------------
	// enable pulses
	// --------------------
	tick_gen #(.DIV(SEC_DIV)) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	tick_gen #(.DIV(DEB_DIV)) u_deb_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (deb_tick)
	);

	// --------------------
	// control and time path
	// --------------------
	button_ctrl u_button_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_deb_tick (deb_tick),
		.i_btn_mode (i_btn_mode),
		.i_btn_pos  (i_btn_pos),
		.i_btn_inc  (i_btn_inc),
		.o_mode     (mode),
		.o_pos      (pos),
		.o_inc      (inc)
	);

	time_counter u_time_counter (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_sec_tick (sec_tick),
		.i_mode     (mode),
		.i_pos      (pos),
		.i_inc      (inc),
		.tm         (u_time_if.producer)
	);

	digit_frame u_digit_frame (
		.clk     (clk),
		.rst_n   (rst_n),
		.tm      (u_time_if.consumer),
		.o_frame (frame)
	);

	display_scan u_display_scan (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_frame     (frame),
		.o_seg       (o_seg),
		.o_seg_en    (o_seg_en)
	);

endmodule

// ==== verilog/display_scan.sv ====
module display_scan (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic                                     i_scan_tick,
	input  clock_pkg::seg_t [clock_pkg::NUM_DIGITS-1:0] i_frame,
	output clock_pkg::seg_t                          o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0]         o_seg_en	// active low
);
	import clock_pkg::*;

	localparam int IDX_W = $clog2(NUM_DIGITS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_DIGITS - 1);

	logic [IDX_W-1:0] idx_q;
	logic [IDX_W-1:0] idx_next;

	always_comb begin
		if (!i_scan_tick) begin
			idx_next = idx_q;
		end else if (idx_q == LAST_IDX) begin
			idx_next = '0;	// wrap after the last digit
		end else begin
			idx_next = idx_q + 1'b1;
		end
	end

	// --------------------
	// scan registers
	// --------------------
	// segments and enable both come from idx_next so they switch together
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx_q    <= '0;
			o_seg    <= SEG_BLANK;
			o_seg_en <= ~NUM_DIGITS'(1);	// digit 0 on
		end else begin
			idx_q    <= idx_next;
			o_seg    <= i_frame[idx_next];
			o_seg_en <= ~(NUM_DIGITS'(1) << idx_next);
		end
	end

	// two digits on at once would ghost the display
	a_one_cold: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_en));

endmodule

// ==== verilog/digit_frame.sv ====
module digit_frame (
	input  logic                                     clk,
	input  logic                                     rst_n,
	time_if.consumer                                 tm,
	output clock_pkg::seg_t [clock_pkg::NUM_DIGITS-1:0] o_frame
);
	import clock_pkg::*;

	// digit order, index 0 first:
	// hour tens, hour ones, minute tens, minute ones, second tens, second ones
	logic [3:0] digit [NUM_DIGITS];

	function automatic seg_t dec_digit(input logic [3:0] d);
		seg_t seg;
		seg = SEG_BLANK;	// anything past 9 stays dark
		if (d <= 4'd9) begin
			seg = SEG_TABLE[d];
		end
		return seg;
	endfunction

	// --------------------
	// split into digits
	// --------------------
	always_comb begin
		digit[0] = 4'(tm.hr / 10);
		digit[1] = 4'(tm.hr % 10);
		digit[2] = 4'(tm.min / 10);
		digit[3] = 4'(tm.min % 10);
		digit[4] = 4'(tm.sec / 10);
		digit[5] = 4'(tm.sec % 10);
	end

	// --------------------
	// segment frame
	// --------------------
	// held between updates so the scan always sees a consistent time
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_DIGITS; i++) begin
				o_frame[i] <= SEG_TABLE[0];	// matches 00:00:00
			end
		end else if (tm.upd) begin
			for (int i = 0; i < NUM_DIGITS; i++) begin
				o_frame[i] <= dec_digit(digit[i]);
			end
		end
	end

endmodule

// ==== verilog/time_counter.sv ====
module time_counter (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_sec_tick,
	input  clock_pkg::mode_e i_mode,
	input  clock_pkg::pos_e  i_pos,
	input  logic             i_inc,
	time_if.producer         tm
);
	import clock_pkg::*;

	field_t sec_q;
	field_t min_q;
	field_t hr_q;
	field_t sec_n;
	field_t min_n;
	field_t hr_n;
	logic   upd_q;
	logic   advance;
	logic   bump;

	function automatic field_t wrap_inc(input field_t val, input field_t lim);
		field_t res;
		res = (val >= lim) ? '0 : field_t'(val + 1'b1);
		return res;
	endfunction

	assign advance = (i_mode == MODE_CLOCK) && i_sec_tick;
	assign bump    = (i_mode == MODE_SETUP) && i_inc;	// second tick ignored here

	// --------------------
	// next time
	// --------------------
	always_comb begin
		sec_n = sec_q;
		min_n = min_q;
		hr_n  = hr_q;
		if (advance) begin
			sec_n = wrap_inc(sec_q, SEC_MAX);
			if (sec_q == SEC_MAX) begin
				min_n = wrap_inc(min_q, MIN_MAX);
				if (min_q == MIN_MAX) begin
					hr_n = wrap_inc(hr_q, HR_MAX);
				end
			end
		end else if (bump) begin
			// selected field only, no carry
			case (i_pos)
				POS_SEC: sec_n = wrap_inc(sec_q, SEC_MAX);
				POS_MIN: min_n = wrap_inc(min_q, MIN_MAX);
				default: hr_n  = wrap_inc(hr_q, HR_MAX);
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec_q <= '0;
			min_q <= '0;
			hr_q  <= '0;
			upd_q <= 1'b0;
		end else begin
			sec_q <= sec_n;
			min_q <= min_n;
			hr_q  <= hr_n;
			upd_q <= advance || bump;	// strobe lands with the new fields
		end
	end

	assign tm.sec = sec_q;
	assign tm.min = min_q;
	assign tm.hr  = hr_q;
	assign tm.upd = upd_q;

	a_sec_lim: assert property (@(posedge clk) disable iff (!rst_n) sec_q <= SEC_MAX);
	a_min_lim: assert property (@(posedge clk) disable iff (!rst_n) min_q <= MIN_MAX);
	a_hr_lim: assert property (@(posedge clk) disable iff (!rst_n) hr_q <= HR_MAX);

endmodule

// ==== verilog/button_ctrl.sv ====
module button_ctrl (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_deb_tick,
	input  logic             i_btn_mode,
	input  logic             i_btn_pos,
	input  logic             i_btn_inc,
	output clock_pkg::mode_e o_mode,
	output clock_pkg::pos_e  o_pos,
	output logic             o_inc
);
	import clock_pkg::*;

	localparam int NUM_BTN  = 3;
	localparam int BTN_MODE = 0;
	localparam int BTN_POS  = 1;
	localparam int BTN_INC  = 2;

	logic [NUM_BTN-1:0] btn_raw;
	logic [NUM_BTN-1:0] sync_q1;
	logic [NUM_BTN-1:0] sync_q2;
	logic [NUM_BTN-1:0] samp_q1;	// latest debounce sample
	logic [NUM_BTN-1:0] samp_q2;	// sample before that
	logic [NUM_BTN-1:0] press;

	assign btn_raw = {i_btn_inc, i_btn_pos, i_btn_mode};

	// --------------------
	// sync and debounce
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
			samp_q1 <= '0;
			samp_q2 <= '0;
		end else begin
			sync_q1 <= btn_raw;
			sync_q2 <= sync_q1;
			if (i_deb_tick) begin
				samp_q1 <= sync_q2;
				samp_q2 <= samp_q1;
			end
		end
	end

	// low, then two highs in a row
	assign press = i_deb_tick ? (sync_q2 & samp_q1 & ~samp_q2) : '0;

	// --------------------
	// mode and position
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= MODE_CLOCK;
			o_pos  <= POS_SEC;
			o_inc  <= 1'b0;
		end else begin
			// a mode press wins over an increment in the same sample
			o_inc <= press[BTN_INC] && !press[BTN_MODE] && (o_mode == MODE_SETUP);
			if (press[BTN_MODE]) begin
				if (o_mode == MODE_CLOCK) begin
					o_mode <= MODE_SETUP;
					o_pos  <= POS_SEC;	// setup always starts on seconds
				end else begin
					o_mode <= MODE_CLOCK;
				end
			end else if (press[BTN_POS] && (o_mode == MODE_SETUP)) begin
				case (o_pos)
					POS_SEC: o_pos <= POS_MIN;
					POS_MIN: o_pos <= POS_HR;
					default: o_pos <= POS_SEC;
				endcase
			end
		end
	end

	// the counter relies on this to keep clock mode free of edits
	a_inc_setup: assert property (@(posedge clk) disable iff (!rst_n)
		o_inc |-> (o_mode == MODE_SETUP));

endmodule

// ==== verilog/tick_gen.sv ====
module tick_gen #(
	parameter int DIV = 4
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);
	localparam int CNT_W = (DIV > 2) ? $clog2(DIV) : 1;
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(DIV - 1);

	logic [CNT_W-1:0] cnt;

	// down-counter, one enable pulse per DIV cycles
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= RELOAD;
			o_tick <= 1'b0;
		end else begin
			if (cnt == '0) begin
				cnt    <= RELOAD;
				o_tick <= 1'b1;	// first pulse lands DIV cycles after reset
			end else begin
				cnt    <= cnt - 1'b1;
				o_tick <= 1'b0;
			end
		end
	end

	// a divide by one would hold the tick high and break every consumer
	a_div_min: assert property (@(posedge clk) disable iff (!rst_n)
		DIV >= 2);

endmodule

// ==== verilog/time_if.sv ====
// current time from the counter to the frame buffer
// upd is high for one cycle exactly when the fields take a new value
interface time_if;
	import clock_pkg::*;

	field_t sec;
	field_t min;
	field_t hr;
	logic   upd;	// one-cycle update strobe

	modport producer (
		output sec,
		output min,
		output hr,
		output upd
	);

	// no back-pressure, the frame buffer always takes the update
	modport consumer (
		input sec,
		input min,
		input hr,
		input upd
	);

endinterface

// ==== verilog/clock_pkg.sv ====
package clock_pkg;

	// --------------------
	// modes and setup fields
	// --------------------
	typedef enum logic {
		MODE_CLOCK = 1'b0,	// time runs
		MODE_SETUP = 1'b1	// time held, fields editable
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HR  = 2'd2
	} pos_e;

	// --------------------
	// widths and limits
	// --------------------
	localparam int FIELD_W    = 6;
	localparam int SEG_W      = 7;	// {a, b, c, d, e, f, g}
	localparam int NUM_DIGITS = 6;

	typedef logic [FIELD_W-1:0] field_t;
	typedef logic [SEG_W-1:0]   seg_t;

	localparam field_t SEC_MAX = 6'd59;
	localparam field_t MIN_MAX = 6'd59;
	localparam field_t HR_MAX  = 6'd23;

	// --------------------
	// digit patterns, active high
	// --------------------
	localparam seg_t SEG_TABLE [0:9] = '{
		7'b111_1110,	// 0
		7'b011_0000,	// 1
		7'b110_1101,	// 2
		7'b111_1001,	// 3
		7'b011_0011,	// 4
		7'b101_1011,	// 5
		7'b101_1111,	// 6
		7'b111_0000,	// 7
		7'b111_1111,	// 8
		7'b111_0011	// 9
	};

	localparam seg_t SEG_BLANK = 7'b000_0000;

endpackage
